// ==== hw/b2s_pkg.sv ====
package b2s_pkg;

  // Bus widths.
  localparam int ADDR_W = 32;
  localparam int ID_W = 4;
  localparam int LEN_W = 8;

  // Every beat moves one full 32-bit word.
  localparam int BYTES_PER_BEAT = 4;

  // Response FIFO geometry.
  localparam int B_DEPTH = 4;
  localparam int B_PTR_W = $clog2(B_DEPTH);
  localparam int B_CNT_W = $clog2(B_DEPTH + 1);

  // Write command FSM states.
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    CMD_EN       = 2'd1,
    CMD_ACCEPTED = 2'd2,
    DONE_WAIT    = 2'd3
  } wr_state_t;

  // Write response codes, ordered so that a larger code is a worse outcome.
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    EXOKAY = 2'd1,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_t;

endpackage

// ==== hw/b2s_wr_cmd_fsm.sv ====
`timescale 1ns/1ns

module b2s_wr_cmd_fsm (
  input  logic clk,
  input  logic reset,
  input  logic s_awvalid,
  output logic s_awready,
  output logic m_awvalid,
  input  logic m_awready,
  output logic next,
  input  logic next_pending,
  output logic b_push,
  input  logic b_full,
  output logic a_push
);

  import b2s_pkg::*;

  wr_state_t state;
  wr_state_t state_next;
  logic      burst_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (s_awvalid) begin
          state_next = CMD_EN;
        end
      end
      CMD_EN: begin
        if (m_awready) begin
          if (next_pending) begin
            state_next = CMD_ACCEPTED;
          end else if (b_full) begin
            state_next = DONE_WAIT;
          end else begin
            state_next = IDLE;
          end
        end
      end
      // One bubble cycle lets the translator step to the next address.
      CMD_ACCEPTED: begin
        state_next = CMD_EN;
      end
      DONE_WAIT: begin
        if (!b_full) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // The burst is finished once the last beat is out and the FIFO has room.
  assign burst_done = ((state == CMD_EN) || (state == DONE_WAIT)) && (state_next == IDLE);

  assign m_awvalid = (state == CMD_EN);
  assign a_push    = (state == IDLE);
  assign next      = (state == CMD_ACCEPTED) || burst_done;
  assign s_awready = burst_done;
  assign b_push    = burst_done;

endmodule

// ==== hw/b2s_wr_cmd_xlat.sv ====
`timescale 1ns/1ns

module b2s_wr_cmd_xlat (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       a_push,
  input  logic [b2s_pkg::ID_W-1:0]   s_awid,
  input  logic [b2s_pkg::ADDR_W-1:0] s_awaddr,
  input  logic [b2s_pkg::LEN_W-1:0]  s_awlen,
  input  logic                       next,
  output logic                       next_pending,
  output logic [b2s_pkg::ADDR_W-1:0] m_awaddr,
  output logic [b2s_pkg::ID_W-1:0]   burst_id,
  output logic [b2s_pkg::LEN_W-1:0]  burst_len
);

  import b2s_pkg::*;

  logic [ADDR_W-1:0] addr;
  logic [ID_W-1:0]   id;
  logic [LEN_W-1:0]  len;
  logic [LEN_W-1:0]  beats_left;

  // Remaining beat count after the one currently on the master channel.
  always_ff @(posedge clk) begin
    if (reset) begin
      beats_left <= '0;
    end else if (a_push) begin
      beats_left <= s_awlen;
    end else if (next && (beats_left != '0)) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  // Start address and burst tag are captured while the FSM waits in IDLE.
  always_ff @(posedge clk) begin
    if (a_push) begin
      addr <= s_awaddr;
      id   <= s_awid;
      len  <= s_awlen;
    end else if (next) begin
      addr <= addr + ADDR_W'(BYTES_PER_BEAT);
    end
  end

  assign next_pending = (beats_left != '0);
  assign m_awaddr     = addr;

  // The original length goes with the burst into the response FIFO.
  assign burst_id  = id;
  assign burst_len = len;

endmodule

// ==== hw/b2s_b_fifo.sv ====
`timescale 1ns/1ns

module b2s_b_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      b_push,
  input  logic [b2s_pkg::ID_W-1:0]  push_id,
  input  logic [b2s_pkg::LEN_W-1:0] push_len,
  output logic                      b_full,
  input  logic                      b_pop,
  output logic                      b_empty,
  output logic [b2s_pkg::ID_W-1:0]  pop_id,
  output logic [b2s_pkg::LEN_W-1:0] pop_len
);

  import b2s_pkg::*;

  logic [ID_W-1:0]    id_mem [B_DEPTH];
  logic [LEN_W-1:0]   len_mem [B_DEPTH];
  logic [B_PTR_W-1:0] wr_ptr;
  logic [B_PTR_W-1:0] rd_ptr;
  logic [B_CNT_W-1:0] count;
  logic               do_push;
  logic               do_pop;

  assign do_push = b_push && !b_full;
  assign do_pop  = b_pop && !b_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      id_mem[wr_ptr]  <= push_id;
      len_mem[wr_ptr] <= push_len;
    end
  end

  assign b_full  = (count == B_CNT_W'(B_DEPTH));
  assign b_empty = (count == '0);
  assign pop_id  = id_mem[rd_ptr];
  assign pop_len = len_mem[rd_ptr];

endmodule

// ==== hw/b2s_b_merge.sv ====
`timescale 1ns/1ns

module b2s_b_merge (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      b_empty,
  input  logic [b2s_pkg::ID_W-1:0]  pop_id,
  input  logic [b2s_pkg::LEN_W-1:0] pop_len,
  output logic                      b_pop,
  input  logic                      m_bvalid,
  output logic                      m_bready,
  input  logic [1:0]                m_bresp,
  output logic                      s_bvalid,
  input  logic                      s_bready,
  output logic [b2s_pkg::ID_W-1:0]  s_bid,
  output logic [1:0]                s_bresp
);

  import b2s_pkg::*;

  logic             loaded;
  logic [ID_W-1:0]  id;
  logic [LEN_W-1:0] beats_left;
  resp_t            worst;
  logic             beat_rsp;

  // A new burst is taken from the FIFO only once the previous one has gone upstream.
  assign b_pop    = !loaded && !b_empty;
  assign m_bready = loaded && !s_bvalid;
  assign beat_rsp = m_bvalid && m_bready;

  always_ff @(posedge clk) begin
    if (reset) begin
      loaded   <= 1'b0;
      s_bvalid <= 1'b0;
    end else begin
      if (b_pop) begin
        loaded <= 1'b1;
      end else if (s_bvalid && s_bready) begin
        loaded   <= 1'b0;
        s_bvalid <= 1'b0;
      end else if (beat_rsp && (beats_left == '0)) begin
        s_bvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (b_pop) begin
      id         <= pop_id;
      beats_left <= pop_len;
      worst      <= OKAY;
    end else if (beat_rsp) begin
      if (beats_left != '0) begin
        beats_left <= beats_left - 1'b1;
      end
      // Keep the numerically largest code seen so far.
      if (m_bresp > worst) begin
        worst <= resp_t'(m_bresp);
      end
    end
  end

  assign s_bid   = id;
  assign s_bresp = worst;

endmodule

// ==== hw/b2s_wr_top.sv ====
`timescale 1ns/1ns

module b2s_wr_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       s_awvalid,
  output logic                       s_awready,
  input  logic [b2s_pkg::ID_W-1:0]   s_awid,
  input  logic [b2s_pkg::ADDR_W-1:0] s_awaddr,
  input  logic [b2s_pkg::LEN_W-1:0]  s_awlen,
  output logic                       s_bvalid,
  input  logic                       s_bready,
  output logic [b2s_pkg::ID_W-1:0]   s_bid,
  output logic [1:0]                 s_bresp,
  output logic                       m_awvalid,
  input  logic                       m_awready,
  output logic [b2s_pkg::ADDR_W-1:0] m_awaddr,
  input  logic                       m_bvalid,
  output logic                       m_bready,
  input  logic [1:0]                 m_bresp
);

  import b2s_pkg::*;

  logic             a_push;
  logic             next;
  logic             next_pending;
  logic             b_push;
  logic             b_full;
  logic             b_pop;
  logic             b_empty;
  logic [ID_W-1:0]  burst_id;
  logic [LEN_W-1:0] burst_len;
  logic [ID_W-1:0]  pop_id;
  logic [LEN_W-1:0] pop_len;

  b2s_wr_cmd_fsm i_wr_cmd_fsm (
    .clk          (clk),
    .reset        (reset),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .m_awvalid    (m_awvalid),
    .m_awready    (m_awready),
    .next         (next),
    .next_pending (next_pending),
    .b_push       (b_push),
    .b_full       (b_full),
    .a_push       (a_push)
  );

  b2s_wr_cmd_xlat i_wr_cmd_xlat (
    .clk          (clk),
    .reset        (reset),
    .a_push       (a_push),
    .s_awid       (s_awid),
    .s_awaddr     (s_awaddr),
    .s_awlen      (s_awlen),
    .next         (next),
    .next_pending (next_pending),
    .m_awaddr     (m_awaddr),
    .burst_id     (burst_id),
    .burst_len    (burst_len)
  );

  b2s_b_fifo i_b_fifo (
    .clk      (clk),
    .reset    (reset),
    .b_push   (b_push),
    .push_id  (burst_id),
    .push_len (burst_len),
    .b_full   (b_full),
    .b_pop    (b_pop),
    .b_empty  (b_empty),
    .pop_id   (pop_id),
    .pop_len  (pop_len)
  );

  b2s_b_merge i_b_merge (
    .clk      (clk),
    .reset    (reset),
    .b_empty  (b_empty),
    .pop_id   (pop_id),
    .pop_len  (pop_len),
    .b_pop    (b_pop),
    .m_bvalid (m_bvalid),
    .m_bready (m_bready),
    .m_bresp  (m_bresp),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .s_bid    (s_bid),
    .s_bresp  (s_bresp)
  );

endmodule

// ==== verif/b2s_clk_gen.sv ====
`timescale 1ns/1ns

module b2s_clk_gen (
  output logic clk,
  output logic reset
);

  // 10 ns clock period.
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset is released just after the 16th rising edge.
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== verif/b2s_tb_assert.sv ====
`timescale 1ns/1ns

module b2s_tb_assert (
  input logic                       clk,
  input logic                       reset,
  input logic                       m_awvalid,
  input logic                       m_awready,
  input logic [b2s_pkg::ADDR_W-1:0] m_awaddr,
  input logic                       s_bvalid,
  input logic                       s_bready,
  input logic [b2s_pkg::ID_W-1:0]   s_bid,
  input logic [1:0]                 s_bresp,
  input logic                       next,
  input logic                       s_awready
);

  int unsigned fail_count = 0;
  logic        in_cmd_accepted;

  // CMD_ACCEPTED is the only state that steps the translator without finishing a burst.
  assign in_cmd_accepted = next && !s_awready;

  aw_hold: assert property (@(posedge clk) disable iff (reset)
    (m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_awaddr)))
  else begin
    fail_count++;
    $error("m_awvalid dropped or m_awaddr changed before the command was accepted");
  end

  b_hold: assert property (@(posedge clk) disable iff (reset)
    (s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bid) && $stable(s_bresp)))
  else begin
    fail_count++;
    $error("s_bvalid dropped or s_bid/s_bresp changed before the response was taken");
  end

  accepted_once: assert property (@(posedge clk) disable iff (reset)
    in_cmd_accepted |=> !in_cmd_accepted)
  else begin
    fail_count++;
    $error("write command FSM stayed in CMD_ACCEPTED for two cycles");
  end

endmodule

bind b2s_wr_top b2s_tb_assert i_tb_assert (
  .clk       (clk),
  .reset     (reset),
  .m_awvalid (m_awvalid),
  .m_awready (m_awready),
  .m_awaddr  (m_awaddr),
  .s_bvalid  (s_bvalid),
  .s_bready  (s_bready),
  .s_bid     (s_bid),
  .s_bresp   (s_bresp),
  .next      (next),
  .s_awready (s_awready)
);

// ==== verif/b2s_tb.sv ====
`timescale 1ns/1ns

module b2s_tb;

  import b2s_pkg::*;

  logic              clk;
  logic              reset;
  logic              s_awvalid;
  logic              s_awready;
  logic [ID_W-1:0]   s_awid;
  logic [ADDR_W-1:0] s_awaddr;
  logic [LEN_W-1:0]  s_awlen;
  logic              s_bvalid;
  logic              s_bready;
  logic [ID_W-1:0]   s_bid;
  logic [1:0]        s_bresp;
  logic              m_awvalid;
  logic              m_awready;
  logic [ADDR_W-1:0] m_awaddr;
  logic              m_bvalid;
  logic              m_bready;
  logic [1:0]        m_bresp;

  logic [ID_W-1:0]   burst_id_q[$];
  logic [ADDR_W-1:0] burst_addr_q[$];
  logic [LEN_W-1:0]  burst_len_q[$];
  int                cum_beats_q[$];
  logic [ADDR_W-1:0] exp_addr_q[$];
  logic [1:0]        beat_resp_q[$];
  logic [ID_W-1:0]   exp_id_q[$];
  logic [1:0]        exp_resp_q[$];

  int   num_bursts = 0;
  int   total_beats = 0;
  int   cmd_count = 0;
  int   aw_done = 0;
  int   resp_count = 0;
  int   beats_resp = 0;
  int   gap_len = 0;
  logic in_gap = 1'b0;
  logic hold_bready_low = 1'b1;

  b2s_clk_gen i_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  b2s_wr_top i_b2s_wr_top (
    .clk       (clk),
    .reset     (reset),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_awid    (s_awid),
    .s_awaddr  (s_awaddr),
    .s_awlen   (s_awlen),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_bid     (s_bid),
    .s_bresp   (s_bresp),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_awaddr  (m_awaddr),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .m_bresp   (m_bresp)
  );

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    abort_run();
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic load_testdata();
    int               fd;
    int               n;
    logic [7:0]       kind;
    logic [31:0]      f1;
    logic [31:0]      f2;
    logic [31:0]      f3;
    logic [8*128-1:0] rest;
    fd = $fopen("verif/b2s_testdata.txt", "r");
    if (fd == 0) report_error("cannot open verif/b2s_testdata.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      case (kind)
        "A": begin
          n = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (n != 3) report_error("malformed A line in the test data");
          burst_id_q.push_back(f1[ID_W-1:0]);
          burst_addr_q.push_back(f2);
          burst_len_q.push_back(f3[LEN_W-1:0]);
          // Beat b of a burst goes to the start address plus four bytes per beat.
          for (int b = 0; b <= int'(f3[LEN_W-1:0]); b++) begin
            exp_addr_q.push_back(f2 + 32'(BYTES_PER_BEAT * b));
          end
          total_beats += int'(f3[LEN_W-1:0]) + 1;
          cum_beats_q.push_back(total_beats);
        end
        "R": begin
          n = $fscanf(fd, "%h", f1);
          if (n != 1) report_error("malformed R line in the test data");
          beat_resp_q.push_back(f1[1:0]);
        end
        "E": begin
          n = $fscanf(fd, "%h %h", f1, f2);
          if (n != 2) report_error("malformed E line in the test data");
          exp_id_q.push_back(f1[ID_W-1:0]);
          exp_resp_q.push_back(f2[1:0]);
        end
        "#": n = $fgets(rest, fd);
        default: report_error("unknown line type in the test data");
      endcase
    end
    $fclose(fd);
    num_bursts = burst_id_q.size();
    assert (beat_resp_q.size() == total_beats)
      else report_error("number of R lines does not match the number of beats");
    assert (exp_id_q.size() == num_bursts)
      else report_error("number of E lines does not match the number of bursts");
  endtask

  initial begin : upstream_aw
    s_awvalid = 1'b0;
    s_awid = '0;
    s_awaddr = '0;
    s_awlen = '0;
    @(negedge reset);
    for (int i = 0; i < num_bursts; i++) begin
      drive_slot();
      repeat ($urandom_range(2, 0)) drive_slot();
      s_awvalid = 1'b1;
      s_awid = burst_id_q[i];
      s_awaddr = burst_addr_q[i];
      s_awlen = burst_len_q[i];
      do begin
        @(negedge clk);
      end while (!s_awready);
      drive_slot();
      s_awvalid = 1'b0;
    end
  end

  initial begin : downstream_aw_ready
    m_awready = 1'b0;
    @(negedge reset);
    forever begin
      drive_slot();
      m_awready = ($urandom_range(3, 0) != 0);
    end
  end

  // Downstream slave answers every accepted command with the next R line.
  initial begin : downstream_b
    m_bvalid = 1'b0;
    m_bresp = '0;
    @(negedge reset);
    forever begin
      drive_slot();
      if (beats_resp < cmd_count) begin
        repeat ($urandom_range(3, 0)) drive_slot();
        m_bvalid = 1'b1;
        m_bresp = beat_resp_q[beats_resp];
        do begin
          @(negedge clk);
        end while (!m_bready);
        drive_slot();
        m_bvalid = 1'b0;
        beats_resp++;
      end
    end
  end

  initial begin : upstream_b_ready
    s_bready = 1'b0;
    @(negedge reset);
    forever begin
      drive_slot();
      if (hold_bready_low) s_bready = 1'b0;
      else s_bready = ($urandom_range(3, 0) != 0);
    end
  end

  // Outputs are sampled on the falling edge, where they show the coming transfer.
  always @(negedge clk) begin
    if (!reset) begin
      assert (i_b2s_wr_top.i_tb_assert.fail_count == 0)
        else report_error("a bound protocol assertion failed");
      if (in_gap) begin
        if (m_awvalid) begin
          assert (gap_len == 1) else report_mismatch("m_awvalid low cycles", 1, 32'(gap_len));
          in_gap = 1'b0;
        end else begin
          gap_len++;
        end
      end
      if (m_awvalid && m_awready) begin
        assert (cmd_count < total_beats) else report_error("more master commands than beats");
        assert (m_awaddr == exp_addr_q[cmd_count])
          else report_mismatch("m_awaddr", exp_addr_q[cmd_count], m_awaddr);
        cmd_count++;
        if (cmd_count < cum_beats_q[aw_done]) begin
          in_gap = 1'b1;
          gap_len = 0;
        end
      end
      if (s_awready) begin
        assert (s_awvalid) else report_error("s_awready high with no burst offered");
        assert (cmd_count == cum_beats_q[aw_done])
          else report_mismatch("commands at s_awready", 32'(cum_beats_q[aw_done]),
                               32'(cmd_count));
        aw_done++;
      end
      if (s_bvalid && s_bready) begin
        assert (resp_count < num_bursts) else report_error("more responses than bursts");
        assert (s_bid == exp_id_q[resp_count])
          else report_mismatch("s_bid", 32'(exp_id_q[resp_count]), 32'(s_bid));
        assert (s_bresp == exp_resp_q[resp_count])
          else report_mismatch("s_bresp", 32'(exp_resp_q[resp_count]), 32'(s_bresp));
        resp_count++;
      end
      // Beat responses are taken only for a loaded burst whose response is not yet offered.
      if (s_bvalid || (aw_done == resp_count)) begin
        assert (!m_bready) else report_mismatch("m_bready", 0, 32'(m_bready));
      end
      // The FIFO holds B_DEPTH bursts and the merger one more.
      assert (aw_done - resp_count <= B_DEPTH + 1)
        else report_error("more bursts pending than the FIFO and merger can hold");
    end
  end

  initial begin : watchdog
    @(negedge reset);
    repeat (200 * num_bursts) @(posedge clk);
    report_error("timeout, the bursts did not complete within 200 cycles each");
  end

  initial begin : main_sequence
    void'($urandom(32'h3f161f3c));
    load_testdata();
    @(negedge reset);
    @(negedge clk);
    assert (!m_awvalid) else report_mismatch("m_awvalid", 0, 32'(m_awvalid));
    assert (!s_awready) else report_mismatch("s_awready", 0, 32'(s_awready));
    assert (!s_bvalid) else report_mismatch("s_bvalid", 0, 32'(s_bvalid));
    assert (!m_bready) else report_mismatch("m_bready", 0, 32'(m_bready));
    // A long stretch of s_bready low must fill the response path and stall command issue.
    repeat (300) @(negedge clk);
    assert (aw_done - resp_count == B_DEPTH + 1)
      else report_mismatch("bursts pending at stall", 32'(B_DEPTH + 1),
                           32'(aw_done - resp_count));
    hold_bready_low = 1'b0;
    while (resp_count < num_bursts) @(negedge clk);
    if ((cmd_count == total_beats) && (aw_done == num_bursts)) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_error("command or burst count at the end of the run is wrong");
    end
  end

endmodule

// ==== verif/b2s_testdata.txt ====
# A id addr len (hex), R beat response in beat order, E expected id and response per burst
# Responses are 0 OKAY, 1 EXOKAY, 2 SLVERR, 3 DECERR
A 3 00001000 00
R 0
E 3 0
A 5 00002000 03
R 0
R 1
R 0
R 0
E 5 1
A a 0000a0f0 01
R 2
R 0
E a 2
A 1 10000000 00
R 3
E 1 3
A 7 00000ffc 01
R 0
R 0
E 7 0
A c 20000040 02
R 1
R 3
R 2
E c 3
A 0 00000010 00
R 1
E 0 1
A f fffffff8 01
R 0
R 2
E f 2
A 2 00004400 00
R 0
E 2 0

// ==== sim.f ====
hw/b2s_pkg.sv
hw/b2s_wr_cmd_fsm.sv
hw/b2s_wr_cmd_xlat.sv
hw/b2s_b_fifo.sv
hw/b2s_b_merge.sv
hw/b2s_wr_top.sv
verif/b2s_clk_gen.sv
verif/b2s_tb_assert.sv
verif/b2s_tb.sv

// ==== Makefile ====
# Verilator build and run for the burst to single-beat write converter.

VERILATOR   ?= verilator
TOP         ?= b2s_tb
FILELIST    ?= sim.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert
RUN_FLAGS   ?= +verilator+error+limit+100
PASS_STRING ?= ALL CHECKS PASSED

SOURCES := $(wildcard hw/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
